// ==== include/demodAddrMap.svh ====
// Register byte offsets and field bit positions of the demodulator control block.
`ifndef DEMOD_ADDR_MAP_SVH
`define DEMOD_ADDR_MAP_SVH

`define DEMOD_CONTROL       8'h00
`define DEMOD_DACSELECT     8'h04
`define DEMOD_FALSELOCK     8'h08
`define DEMOD_STATUS        8'h0C
`define DEMOD_AMTC          8'h10
`define DEMOD_FSKDEV        8'h14

// Field positions.
`define CTRL_MODE_LSB       0
`define CTRL_ITHENQ_BIT     13
`define CTRL_SCPATH_BIT     14
`define CTRL_DESPREAD_BIT   15
`define DAC_SEL_STRIDE      8
`define FL_ALPHA_LSB        0
`define FL_THRESH_LSB       16
`define STATUS_LSB          0
`define AMTC_LSB            0
`define FSKDEV_LSB          0

`endif

// ==== design/demodPkg.sv ====
`default_nettype none
// Shared widths, register access structs, configuration and status types, bus state.

package demodPkg;

    localparam int dataWidth      = 32;
    localparam int strbWidth      = dataWidth / 8;
    localparam int regAddrWidth   = 8;
    localparam int metricWidth    = 16;
    localparam int fskWidth       = 16;
    localparam int modeWidth      = 5;
    localparam int amTcWidth      = 5;
    localparam int numDacs        = 3;
    localparam int dacSelWidth    = 4;
    localparam int numTestPoints  = 2 ** dacSelWidth;
    localparam int testPointWidth = 16;

    typedef logic [regAddrWidth-1:0] regAddrT;

    typedef struct packed {
        logic                 en;
        regAddrT              addr;
        logic [dataWidth-1:0] data;
        logic [strbWidth-1:0] strb;
    } regWriteT;

    typedef struct packed {
        logic    en;
        regAddrT addr;
    } regReadT;

    // Packed order puts demodLock at bit 0.
    typedef struct packed {
        logic falseLock;
        logic auBitsyncLock;
        logic highFreqOffset;
        logic bitsyncLock;
        logic demodLock;
    } demodStatusT;

    typedef struct packed {
        logic [modeWidth-1:0]                  demodMode;
        logic                                  oqpskIthenQ;
        logic                                  enableScPath;
        logic                                  enableDespreader;
        logic [numDacs-1:0][dacSelWidth-1:0]   dacSelect;
        logic [metricWidth-1:0]                falseLockAlpha;
        logic [metricWidth-1:0]                falseLockThreshold;
        logic [amTcWidth-1:0]                  amTC;
    } demodConfigT;

    typedef enum logic [1:0] {
        idle,
        writeResp,
        readResp
    } busStateT;

    typedef logic [numTestPoints-1:0][testPointWidth-1:0] testPointsT;

endpackage

`default_nettype wire

// ==== design/axiLiteSlave.sv ====
`default_nettype none
// AXI4-Lite slave that turns bus transfers into register write and read strobes.

module axiLiteSlave #(
    parameter int addrWidth = 8
) (
    input  wire logic                           busClk,
    input  wire logic                           reset,
    input  wire logic [addrWidth-1:0]           awaddr,
    input  wire logic                           awvalid,
    output logic                                awready,
    input  wire logic [demodPkg::dataWidth-1:0] wdata,
    input  wire logic [demodPkg::strbWidth-1:0] wstrb,
    input  wire logic                           wvalid,
    output logic                                wready,
    output logic [1:0]                          bresp,
    output logic                                bvalid,
    input  wire logic                           bready,
    input  wire logic [addrWidth-1:0]           araddr,
    input  wire logic                           arvalid,
    output logic                                arready,
    output logic [demodPkg::dataWidth-1:0]      rdata,
    output logic [1:0]                          rresp,
    output logic                                rvalid,
    input  wire logic                           rready,
    output demodPkg::regWriteT                  regWrite,
    output demodPkg::regReadT                   regRead,
    input  wire logic [demodPkg::dataWidth-1:0] readData
);

    localparam logic [1:0] respOkay = 2'b00;

    demodPkg::busStateT state;
    demodPkg::busStateT nextState;
    logic               idleReady;
    logic               writePending;
    logic               wrAccept;
    logic               rdAccept;

    // Write needs both channels; it wins over a read.
    assign writePending = awvalid && wvalid;
    assign wrAccept     = idleReady && writePending;
    assign rdAccept     = idleReady && arvalid && !writePending;

    assign awready = idleReady;
    assign wready  = idleReady;
    assign arready = idleReady && !writePending;
    assign bvalid  = (state == demodPkg::writeResp);
    assign rvalid  = (state == demodPkg::readResp);
    assign bresp   = respOkay;
    assign rresp   = respOkay;

    // ========================================
    // Bus FSM
    // ========================================
    always_comb begin
        nextState = state;
        case (state)
            demodPkg::idle: begin
                if (wrAccept) begin
                    nextState = demodPkg::writeResp;
                end else if (rdAccept) begin
                    nextState = demodPkg::readResp;
                end
            end
            demodPkg::writeResp: begin
                if (bready) begin
                    nextState = demodPkg::idle;
                end
            end
            demodPkg::readResp: begin
                if (rready) begin
                    nextState = demodPkg::idle;
                end
            end
            default: nextState = demodPkg::idle;
        endcase
    end

    // Ready comes up one cycle after reset.
    always_ff @(posedge busClk) begin
        if (reset) begin
            state     <= demodPkg::idle;
            idleReady <= 1'b0;
        end else begin
            state     <= nextState;
            idleReady <= (nextState == demodPkg::idle);
        end
    end

    always_ff @(posedge busClk) begin
        if (rdAccept) begin
            rdata <= readData;
        end
    end

    // Register strobes.
    always_comb begin
        regWrite.en   = wrAccept;
        regWrite.addr = demodPkg::regAddrT'(awaddr);
        regWrite.data = wdata;
        regWrite.strb = wstrb;
        regRead.en    = rdAccept;
        regRead.addr  = demodPkg::regAddrT'(araddr);
    end

    oneResponse: assert property (@(posedge busClk) disable iff (reset)
        !(bvalid && rvalid));

    rdataHeld: assert property (@(posedge busClk) disable iff (reset)
        rvalid && !rready |=> $stable(rdata));

endmodule

`default_nettype wire

// ==== design/demodRegs.sv ====
`default_nettype none
// Demodulator configuration registers with byte-lane writes and readback mux.

`include "demodAddrMap.svh"

module demodRegs (
    input  wire logic                           busClk,
    input  wire logic                           reset,
    input  wire demodPkg::regWriteT             regWrite,
    input  wire demodPkg::regReadT              regRead,
    input  wire demodPkg::demodStatusT          status,
    input  wire logic [demodPkg::fskWidth-1:0]  fskDeviation,
    output logic [demodPkg::dataWidth-1:0]      readData,
    output demodPkg::demodConfigT               demodConfig
);

    logic [demodPkg::dataWidth-1:0] wrMask;
    logic [demodPkg::dataWidth-1:0] wrMerged;

    // Register image of the writable fields, zero elsewhere.
    function automatic logic [demodPkg::dataWidth-1:0] packConfig(
        input demodPkg::regAddrT     addr,
        input demodPkg::demodConfigT c
    );
        logic [demodPkg::dataWidth-1:0] word;
        word = '0;
        case (addr)
            `DEMOD_CONTROL: begin
                word[`CTRL_MODE_LSB +: demodPkg::modeWidth] = c.demodMode;
                word[`CTRL_ITHENQ_BIT]   = c.oqpskIthenQ;
                word[`CTRL_SCPATH_BIT]   = c.enableScPath;
                word[`CTRL_DESPREAD_BIT] = c.enableDespreader;
            end
            `DEMOD_DACSELECT: begin
                for (int i = 0; i < demodPkg::numDacs; i++) begin
                    word[i*`DAC_SEL_STRIDE +: demodPkg::dacSelWidth] = c.dacSelect[i];
                end
            end
            `DEMOD_FALSELOCK: begin
                word[`FL_ALPHA_LSB +: demodPkg::metricWidth]  = c.falseLockAlpha;
                word[`FL_THRESH_LSB +: demodPkg::metricWidth] = c.falseLockThreshold;
            end
            `DEMOD_AMTC: word[`AMTC_LSB +: demodPkg::amTcWidth] = c.amTC;
            default: word = '0;
        endcase
        return word;
    endfunction

    // Unstrobed bytes keep the current register contents.
    always_comb begin
        for (int i = 0; i < demodPkg::strbWidth; i++) begin
            wrMask[8*i +: 8] = {8{regWrite.strb[i]}};
        end
    end

    assign wrMerged = (packConfig(regWrite.addr, demodConfig) & ~wrMask)
                    | (regWrite.data & wrMask);

    always_ff @(posedge busClk) begin
        if (reset) begin
            demodConfig <= '0;
        end else if (regWrite.en) begin
            case (regWrite.addr)
                `DEMOD_CONTROL: begin
                    demodConfig.demodMode        <= wrMerged[`CTRL_MODE_LSB +: demodPkg::modeWidth];
                    demodConfig.oqpskIthenQ      <= wrMerged[`CTRL_ITHENQ_BIT];
                    demodConfig.enableScPath     <= wrMerged[`CTRL_SCPATH_BIT];
                    demodConfig.enableDespreader <= wrMerged[`CTRL_DESPREAD_BIT];
                end
                `DEMOD_DACSELECT: begin
                    for (int i = 0; i < demodPkg::numDacs; i++) begin
                        demodConfig.dacSelect[i] <=
                            wrMerged[i*`DAC_SEL_STRIDE +: demodPkg::dacSelWidth];
                    end
                end
                `DEMOD_FALSELOCK: begin
                    demodConfig.falseLockAlpha <=
                        wrMerged[`FL_ALPHA_LSB +: demodPkg::metricWidth];
                    demodConfig.falseLockThreshold <=
                        wrMerged[`FL_THRESH_LSB +: demodPkg::metricWidth];
                end
                `DEMOD_AMTC: demodConfig.amTC <= wrMerged[`AMTC_LSB +: demodPkg::amTcWidth];
                default: ;
            endcase
        end
    end

    // Readback. Status registers show live inputs.
    always_comb begin
        readData = '0;
        if (regRead.en) begin
            case (regRead.addr)
                `DEMOD_STATUS: readData[`STATUS_LSB +: $bits(status)] = status;
                `DEMOD_FSKDEV: readData[`FSKDEV_LSB +: demodPkg::fskWidth] = fskDeviation;
                default:       readData = packConfig(regRead.addr, demodConfig);
            endcase
        end
    end

    noEmptyStrobe: assert property (@(posedge busClk) disable iff (reset)
        regWrite.en |-> (regWrite.strb != '0));

endmodule

`default_nettype wire

// ==== design/falseLockDetector.sv ====
`default_nettype none
// False-lock detector: exponential average of the lock metric against a threshold.

module falseLockDetector (
    input  wire logic                              busClk,
    input  wire logic                              reset,
    input  wire logic [demodPkg::metricWidth-1:0]  lockMetric,
    input  wire logic                              metricValid,
    input  wire logic [demodPkg::metricWidth-1:0]  alpha,
    input  wire logic [demodPkg::metricWidth-1:0]  threshold,
    input  wire logic                              demodLock,
    output logic                                   falseLock
);

    localparam int mw = demodPkg::metricWidth;

    logic        [mw-1:0]   avg;
    logic signed [mw:0]     diff;
    logic signed [2*mw+1:0] product;
    logic signed [mw+1:0]   step;
    logic signed [mw+1:0]   nextAvg;

    // ========================================
    // Averaging
    // ========================================
    assign diff    = $signed({1'b0, lockMetric}) - $signed({1'b0, avg});
    assign product = diff * $signed({1'b0, alpha});

    // Upper slice is product >>> mw, floor of the scaled step.
    assign step    = product[2*mw+1:mw];
    assign nextAvg = $signed({2'b00, avg}) + step;

    always_ff @(posedge busClk) begin
        if (reset) begin
            avg <= '0;
        end else if (metricValid) begin
            avg <= nextAvg[mw-1:0];
        end
    end

    // Lock claimed while quality is poor.
    always_ff @(posedge busClk) begin
        if (reset) begin
            falseLock <= 1'b0;
        end else begin
            falseLock <= demodLock && (avg < threshold);
        end
    end

endmodule

`default_nettype wire

// ==== design/dacTestMux.sv ====
`default_nettype none
// Registered DAC test-point selection, three outputs from sixteen sources.

module dacTestMux (
    input  wire logic                                busClk,
    input  wire logic                                reset,
    input  wire demodPkg::testPointsT                testPoints,
    input  wire logic [demodPkg::numDacs-1:0][demodPkg::dacSelWidth-1:0] dacSelect,
    output logic [demodPkg::testPointWidth-1:0]      dacOut0,
    output logic [demodPkg::testPointWidth-1:0]      dacOut1,
    output logic [demodPkg::testPointWidth-1:0]      dacOut2
);

    logic [demodPkg::numDacs-1:0][demodPkg::testPointWidth-1:0] dacReg;

    // One clock-aligned sample per DAC.
    always_ff @(posedge busClk) begin
        if (reset) begin
            dacReg <= '0;
        end else begin
            for (int i = 0; i < demodPkg::numDacs; i++) begin
                dacReg[i] <= testPoints[dacSelect[i]];
            end
        end
    end

    assign dacOut0 = dacReg[0];
    assign dacOut1 = dacReg[1];
    assign dacOut2 = dacReg[2];

endmodule

`default_nettype wire

// ==== design/demodCtrlTop.sv ====
`default_nettype none
// Demodulator host-control top: bus slave, register bank, false-lock detector, DAC mux.

module demodCtrlTop #(
    parameter int addrWidth = 8
) (
    input  wire logic                                busClk,
    input  wire logic                                reset,
    input  wire logic [addrWidth-1:0]                awaddr,
    input  wire logic                                awvalid,
    output logic                                     awready,
    input  wire logic [demodPkg::dataWidth-1:0]      wdata,
    input  wire logic [demodPkg::strbWidth-1:0]      wstrb,
    input  wire logic                                wvalid,
    output logic                                     wready,
    output logic [1:0]                               bresp,
    output logic                                     bvalid,
    input  wire logic                                bready,
    input  wire logic [addrWidth-1:0]                araddr,
    input  wire logic                                arvalid,
    output logic                                     arready,
    output logic [demodPkg::dataWidth-1:0]           rdata,
    output logic [1:0]                               rresp,
    output logic                                     rvalid,
    input  wire logic                                rready,
    input  wire logic                                demodLock,
    input  wire logic                                bitsyncLock,
    input  wire logic                                highFreqOffset,
    input  wire logic                                auBitsyncLock,
    input  wire logic [demodPkg::fskWidth-1:0]       fskDeviation,
    input  wire logic [demodPkg::metricWidth-1:0]    lockMetric,
    input  wire logic                                metricValid,
    input  wire demodPkg::testPointsT                testPoints,
    output demodPkg::demodConfigT                    demodConfig,
    output logic [demodPkg::testPointWidth-1:0]      dacOut0,
    output logic [demodPkg::testPointWidth-1:0]      dacOut1,
    output logic [demodPkg::testPointWidth-1:0]      dacOut2
);

    demodPkg::regWriteT             regWrite;
    demodPkg::regReadT              regRead;
    demodPkg::demodStatusT          status;
    logic [demodPkg::dataWidth-1:0] readData;
    logic                           falseLock;

    always_comb begin
        status.demodLock      = demodLock;
        status.bitsyncLock    = bitsyncLock;
        status.highFreqOffset = highFreqOffset;
        status.auBitsyncLock  = auBitsyncLock;
        status.falseLock      = falseLock;
    end

    axiLiteSlave #(
        .addrWidth (addrWidth)
    ) uSlave (
        .busClk   (busClk),
        .reset    (reset),
        .awaddr   (awaddr),
        .awvalid  (awvalid),
        .awready  (awready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .wvalid   (wvalid),
        .wready   (wready),
        .bresp    (bresp),
        .bvalid   (bvalid),
        .bready   (bready),
        .araddr   (araddr),
        .arvalid  (arvalid),
        .arready  (arready),
        .rdata    (rdata),
        .rresp    (rresp),
        .rvalid   (rvalid),
        .rready   (rready),
        .regWrite (regWrite),
        .regRead  (regRead),
        .readData (readData)
    );

    demodRegs uRegs (
        .busClk       (busClk),
        .reset        (reset),
        .regWrite     (regWrite),
        .regRead      (regRead),
        .status       (status),
        .fskDeviation (fskDeviation),
        .readData     (readData),
        .demodConfig  (demodConfig)
    );

    falseLockDetector uDetector (
        .busClk      (busClk),
        .reset       (reset),
        .lockMetric  (lockMetric),
        .metricValid (metricValid),
        .alpha       (demodConfig.falseLockAlpha),
        .threshold   (demodConfig.falseLockThreshold),
        .demodLock   (status.demodLock),
        .falseLock   (falseLock)
    );

    dacTestMux uDacMux (
        .busClk     (busClk),
        .reset      (reset),
        .testPoints (testPoints),
        .dacSelect  (demodConfig.dacSelect),
        .dacOut0    (dacOut0),
        .dacOut1    (dacOut1),
        .dacOut2    (dacOut2)
    );

endmodule

`default_nettype wire

// ==== verif/tbClockGen.sv ====
`default_nettype none
// Testbench clock and reset source.

module tbClockGen (
    output logic busClk,
    output logic reset
);

    initial begin
        busClk = 1'b0;
        forever #50 busClk = ~busClk;
    end

    // Reset held over the first 8 rising edges.
    initial begin
        reset = 1'b1;
        repeat (8) @(posedge busClk);
        #10 reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== verif/demodCtrlTb.sv ====
`default_nettype none
// Testbench for the demodulator control block: bus tasks, reference models, checks.

`include "demodAddrMap.svh"

module demodCtrlTb;

    localparam int driveDelay = 10;
    localparam int waitLimit  = 100;
    localparam int ctrlIdx    = `DEMOD_CONTROL / 4;
    localparam int dacIdx     = `DEMOD_DACSELECT / 4;
    localparam int flIdx      = `DEMOD_FALSELOCK / 4;
    localparam int amtcIdx    = `DEMOD_AMTC / 4;

    logic                  busClk;
    logic                  reset;
    logic [7:0]            awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [31:0]           wdata;
    logic [3:0]            wstrb;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    logic [7:0]            araddr;
    logic                  arvalid;
    logic                  arready;
    logic [31:0]           rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;
    logic                  demodLock;
    logic                  bitsyncLock;
    logic                  highFreqOffset;
    logic                  auBitsyncLock;
    logic [15:0]           fskDeviation;
    logic [15:0]           lockMetric;
    logic                  metricValid;
    demodPkg::testPointsT  testPoints;
    demodPkg::demodConfigT demodConfig;
    logic [15:0]           dacOut0;
    logic [15:0]           dacOut1;
    logic [15:0]           dacOut2;

    // Reference state.
    logic [31:0] modelRegs [0:7];
    logic [15:0] modelAvg;
    logic [31:0] lfsrState;

    logic [7:0] writableRegs [0:3] = '{`DEMOD_CONTROL, `DEMOD_DACSELECT,
                                       `DEMOD_FALSELOCK, `DEMOD_AMTC};
    logic [7:0] readableRegs [0:5] = '{`DEMOD_CONTROL, `DEMOD_DACSELECT, `DEMOD_FALSELOCK,
                                       `DEMOD_STATUS, `DEMOD_AMTC, `DEMOD_FSKDEV};
    logic [7:0] ignoredRegs [0:4]  = '{`DEMOD_STATUS, `DEMOD_FSKDEV, 8'h18, 8'h40, 8'hFC};

    tbClockGen clockGen (
        .busClk (busClk),
        .reset  (reset)
    );

    demodCtrlTop #(
        .addrWidth (8)
    ) uut (.*);

    // ========================================
    // Random source and reference models
    // ========================================
    function automatic logic [31:0] galoisStep(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'hD0000001;
        end
        return s >> 1;
    endfunction

    function automatic logic [63:0] randBits(input int n);
        logic [63:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = galoisStep(lfsrState);
            r = {r[62:0], lfsrState[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] fieldMask(input logic [7:0] addr);
        case (addr)
            `DEMOD_CONTROL:   return 32'h0000E01F;
            `DEMOD_DACSELECT: return 32'h000F0F0F;
            `DEMOD_FALSELOCK: return 32'hFFFFFFFF;
            `DEMOD_AMTC:      return 32'h0000001F;
            default:          return 32'h00000000;
        endcase
    endfunction

    function automatic void modelWrite(input logic [7:0] addr, input logic [31:0] data,
                                       input logic [3:0] strb);
        logic [31:0] laneMask;
        for (int i = 0; i < 4; i++) begin
            laneMask[8*i +: 8] = {8{strb[i]}};
        end
        if (fieldMask(addr) != '0) begin
            modelRegs[addr[4:2]] = ((modelRegs[addr[4:2]] & ~laneMask) | (data & laneMask))
                                 & fieldMask(addr);
        end
    endfunction

    // Average moves by alpha/65536 of the difference, floored.
    function automatic logic [15:0] nextAverage(input logic [15:0] avg,
                                                input logic [15:0] metric,
                                                input logic [15:0] alpha);
        longint diff;
        longint prod;
        diff = longint'(metric) - longint'(avg);
        prod = diff * longint'(alpha);
        return 16'(longint'(avg) + (prod >>> 16));
    endfunction

    function automatic logic falseLockModel();
        return demodLock && (modelAvg < modelRegs[flIdx][31:16]);
    endfunction

    function automatic logic [31:0] expectedRead(input logic [7:0] addr);
        logic [31:0] word;
        word = '0;
        case (addr)
            `DEMOD_CONTROL, `DEMOD_DACSELECT, `DEMOD_FALSELOCK, `DEMOD_AMTC:
                word = modelRegs[addr[4:2]];
            `DEMOD_STATUS:
                word[4:0] = {falseLockModel(), auBitsyncLock, highFreqOffset,
                             bitsyncLock, demodLock};
            `DEMOD_FSKDEV: word[15:0] = fskDeviation;
            default:       word = '0;
        endcase
        return word;
    endfunction

    function automatic demodPkg::demodConfigT expectedConfig();
        demodPkg::demodConfigT c;
        c.demodMode        = modelRegs[ctrlIdx][4:0];
        c.oqpskIthenQ      = modelRegs[ctrlIdx][13];
        c.enableScPath     = modelRegs[ctrlIdx][14];
        c.enableDespreader = modelRegs[ctrlIdx][15];
        for (int i = 0; i < 3; i++) begin
            c.dacSelect[i] = modelRegs[dacIdx][8*i +: 4];
        end
        c.falseLockAlpha     = modelRegs[flIdx][15:0];
        c.falseLockThreshold = modelRegs[flIdx][31:16];
        c.amTC               = modelRegs[amtcIdx][4:0];
        return c;
    endfunction

    // ========================================
    // Checks and bus tasks
    // ========================================
    task automatic failNow(input string reason);
        $display("Error: %s", reason);
        $display("TEST FAILED");
        $fatal(1, "Run stopped.");
    endtask

    task automatic compareValue(input string name, input logic [63:0] actual,
                                input logic [63:0] expected);
        if (actual !== expected) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            $display("TEST FAILED");
            $fatal(1, "Mismatch on %s.", name);
        end
    endtask

    task automatic nextCycle();
        @(posedge busClk);
        #driveDelay;
    endtask

    task automatic checkBusOutputs(input logic ready, input logic bv, input logic rv);
        compareValue("awready", 64'(awready), 64'(ready));
        compareValue("wready", 64'(wready), 64'(ready));
        compareValue("arready", 64'(arready), 64'(ready));
        compareValue("bvalid", 64'(bvalid), 64'(bv));
        compareValue("rvalid", 64'(rvalid), 64'(rv));
    endtask

    task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
                            input logic [3:0] strb, input int hold);
        int count;
        count   = 0;
        awaddr  = addr;
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        while (!(awready && wready)) begin
            nextCycle();
            count++;
            if (count > waitLimit) failNow("write address and data were never accepted");
        end
        // Transfer happens on the next edge.
        nextCycle();
        awvalid = 1'b0;
        wvalid  = 1'b0;
        modelWrite(addr, data, strb);
        count = 0;
        while (!bvalid) begin
            nextCycle();
            count++;
            if (count > waitLimit) failNow("write response never arrived");
        end
        compareValue("bresp", 64'(bresp), 64'd0);
        for (int i = 0; i <= hold; i++) begin
            checkBusOutputs(1'b0, 1'b1, 1'b0);
            if (i < hold) nextCycle();
        end
        bready = 1'b1;
        nextCycle();
        bready = 1'b0;
    endtask

    task automatic axiRead(input logic [7:0] addr, output logic [31:0] data, input int hold);
        int count;
        count   = 0;
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready) begin
            nextCycle();
            count++;
            if (count > waitLimit) failNow("read address was never accepted");
        end
        nextCycle();
        arvalid = 1'b0;
        count   = 0;
        while (!rvalid) begin
            nextCycle();
            count++;
            if (count > waitLimit) failNow("read data never arrived");
        end
        data = rdata;
        compareValue("rresp", 64'(rresp), 64'd0);
        for (int i = 0; i <= hold; i++) begin
            checkBusOutputs(1'b0, 1'b0, 1'b1);
            compareValue("rdata", 64'(rdata), 64'(data));
            if (i < hold) nextCycle();
        end
        rready = 1'b1;
        nextCycle();
        rready = 1'b0;
    endtask

    task automatic checkRead(input logic [7:0] addr, input int hold);
        logic [31:0] data;
        axiRead(addr, data, hold);
        compareValue($sformatf("rdata[0x%02h]", addr), 64'(data), 64'(expectedRead(addr)));
    endtask

    // Falls two edges after the sample edge, when falseLock has settled.
    task automatic feedSample(input logic [15:0] metric);
        lockMetric  = metric;
        metricValid = 1'b1;
        nextCycle();
        metricValid = 1'b0;
        modelAvg    = nextAverage(modelAvg, metric, modelRegs[flIdx][15:0]);
        nextCycle();
    endtask

    // Config port against the register model, away from the clock edge.
    always @(negedge busClk) begin
        if (!reset) begin
            compareValue("demodConfig", 64'(demodConfig), 64'(expectedConfig()));
        end
    end

    // ========================================
    // Stimulus
    // ========================================
    initial begin
        logic [31:0]      data;
        logic [7:0]       addr;
        logic [3:0]       strb;
        logic [3:0]       sel;
        logic [15:0]      metric;
        logic [2:0][15:0] dacNow;
        int               count;
        int               aboveCount;
        int               belowCount;

        lfsrState      = 32'd24;
        awaddr         = '0;
        awvalid        = 1'b0;
        wdata          = '0;
        wstrb          = '0;
        wvalid         = 1'b0;
        bready         = 1'b0;
        araddr         = '0;
        arvalid        = 1'b0;
        rready         = 1'b0;
        demodLock      = 1'b0;
        bitsyncLock    = 1'b0;
        highFreqOffset = 1'b0;
        auBitsyncLock  = 1'b0;
        fskDeviation   = '0;
        lockMetric     = '0;
        metricValid    = 1'b0;
        testPoints     = '0;
        modelAvg       = '0;
        count          = 0;
        aboveCount     = 0;
        belowCount     = 0;
        foreach (modelRegs[i]) modelRegs[i] = '0;

        // Outputs stay quiet through reset, then idle.
        nextCycle();
        while (reset !== 1'b0) begin
            @(negedge busClk);
            count++;
            if (count > waitLimit) failNow("reset was never released");
            if (reset === 1'b1) checkBusOutputs(1'b0, 1'b0, 1'b0);
        end
        nextCycle();
        checkBusOutputs(1'b1, 1'b0, 1'b0);
        compareValue("demodConfig", 64'(demodConfig), 64'd0);
        foreach (readableRegs[i]) checkRead(readableRegs[i], 0);

        foreach (writableRegs[i]) begin
            for (int k = 0; k < 4; k++) begin
                axiWrite(writableRegs[i], 32'(randBits(32)), 4'hF, 0);
                checkRead(writableRegs[i], 0);
            end
        end

        for (int k = 0; k < 16; k++) begin
            addr = writableRegs[2'(randBits(2))];
            strb = 4'b0001 << randBits(2);
            axiWrite(addr, 32'(randBits(32)), strb, 0);
            checkRead(addr, 0);
        end

        for (int k = 0; k < 6; k++) begin
            {auBitsyncLock, highFreqOffset, bitsyncLock, demodLock} = 4'(randBits(4));
            fskDeviation = 16'(randBits(16));
            nextCycle();
            checkRead(`DEMOD_STATUS, 0);
            checkRead(`DEMOD_FSKDEV, 0);
        end
        foreach (ignoredRegs[i]) begin
            axiWrite(ignoredRegs[i], 32'(randBits(32)), 4'hF, 0);
            checkRead(ignoredRegs[i], 0);
        end
        foreach (readableRegs[i]) checkRead(readableRegs[i], 0);

        // Random samples, then a pull up and a pull down across the threshold.
        axiWrite(`DEMOD_FALSELOCK, 32'h8000_8000, 4'hF, 0);
        demodLock = 1'b1;
        for (int k = 0; k < 20; k++) begin
            if (k < 12) begin
                metric = 16'(randBits(16));
            end else if (k < 16) begin
                metric = 16'hFFFF;
            end else begin
                metric = 16'h0000;
            end
            feedSample(metric);
            if (falseLockModel()) belowCount++;
            else aboveCount++;
            checkRead(`DEMOD_STATUS, 0);
        end
        if (aboveCount == 0 || belowCount == 0) begin
            failNow("detector average never crossed the threshold in both directions");
        end
        demodLock = 1'b0;
        for (int k = 0; k < 6; k++) begin
            feedSample(16'(randBits(16)));
            axiRead(`DEMOD_STATUS, data, 0);
            compareValue("falseLock", 64'(data[4]), 64'd0);
        end

        for (int k = 0; k < 6; k++) begin
            axiWrite(`DEMOD_DACSELECT, 32'(randBits(32)), 4'hF, 0);
            for (int i = 0; i < 16; i++) testPoints[i] = 16'(randBits(16));
            nextCycle();
            dacNow = {dacOut2, dacOut1, dacOut0};
            for (int i = 0; i < 3; i++) begin
                sel = modelRegs[dacIdx][8*i +: 4];
                compareValue($sformatf("dacOut%0d", i), 64'(dacNow[i]), 64'(testPoints[sel]));
            end
        end

        // Responses held off for several cycles.
        axiWrite(`DEMOD_CONTROL, 32'(randBits(32)), 4'hF, 5);
        checkRead(`DEMOD_CONTROL, 5);

        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== demodCtrl.f ====
+incdir+include
design/demodPkg.sv
design/axiLiteSlave.sv
design/demodRegs.sv
design/falseLockDetector.sv
design/dacTestMux.sv
design/demodCtrlTop.sv
verif/tbClockGen.sv
verif/demodCtrlTb.sv

// ==== runSim.sh ====
#!/usr/bin/env bash
# Build the demodulator control testbench with Verilator and run it.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f demodCtrl.f --top-module demodCtrlTb -o simDemodCtrl
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/simDemodCtrl 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST OK" <<< "$output"; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1
